// ==== tb.f ====
+incdir+verif
common/rdp_pkg.sv
common/read_calib_if.sv
valid_predict/vfifo_group.sv
read_fifo/read_fifo_group.sv
rtl/read_latency_tracker.sv
rtl/read_datapath.sv
verif/tb_read_datapath.sv

// ==== Makefile ====
# Verilator build and run of the read datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_read_datapath
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_util.svh ====
// LFSR stepping for the random stimulus
// Reporting tasks for wrong values and other failures
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

	// Sixteen-bit Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// Takes n bits, one LFSR step per bit, newest bit in bit 0
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// A compared signal that does not match its model
	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("FAILED %s: got 0x%0h, expected 0x%0h at cycle %0d", name, got, expected,
			cyc);
		stop_run();
	endtask

	// Any other failure, stated in words
	task automatic report_error(input string what);
		$display("ERROR: %s at cycle %0d", what, cyc);
		stop_run();
	endtask

`endif

// ==== verif/tb_read_datapath.sv ====
// Testbench for the read datapath with clock, reset and stimulus
// Reference models for latency, valid prediction, termination and FIFO data
module tb_read_datapath;
	timeunit 1ns;
	timeprecision 100ps;
	import rdp_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int LAT_QUIET    = 20;
	localparam int LAT_RUN      = 300;
	localparam int BURST_LEN    = 24;
	localparam int DATA_BUDGET  = 80;
	localparam int VF_BUDGET    = 200;
	localparam int OCT_BUDGET   = 40;
	localparam int TAIL         = 30;
	localparam int PHASE_SUM    = RESET_CYCLES + TAIL + 4 * (LAT_QUIET + LAT_RUN)
		+ 2 * DATA_BUDGET + VF_BUDGET + OCT_BUDGET;
	localparam int TIMEOUT      = PHASE_SUM * 3 / 2;
	localparam int HIST_DEPTH   = 4096;
	localparam int WORDS        = 256;

	logic pll_afi_clk = 1'b0;
	logic reset_n_afi_clk;
	dqs_vec_t seq_read_fifo_reset_i;
	dqs_vec_t seq_read_increment_vfifo_i;
	latency_t seq_read_latency_i;
	logic afi_rdata_en_i;
	logic afi_rdata_en_full_i;
	afi_data_t ddio_phy_dq_i;
	afi_data_t afi_rdata_o;
	logic afi_rdata_valid_o;
	dqs_vec_t dqs_enable_ctrl_o;
	logic force_oct_off_o;

	logic [15:0] lfsr_state = 16'd96;
	int cyc = 0;

	// Request history per edge, bit 0 the narrow request and bit 1 the full one
	logic [1:0] req_hist [HIST_DEPTH];
	int vf_ptr [NUM_DQS_GROUPS] = '{default: 0};
	logic exp_valid = 1'b0;
	logic exp_oct = 1'b0;
	dqs_vec_t exp_dqs = '0;

	// Words written since the last FIFO reset release
	afi_data_t wr_words [WORDS];
	int wr_count = 0;
	logic wr_active = 1'b0;
	int fifo_epoch = 0;
	int seen_epoch = 0;
	int rd_k = 0;
	int words_checked = 0;
	logic data_check_on = 1'b0;

	`include "tb_util.svh"

	read_datapath read_datapath_inst (.*);

	always #2 pll_afi_clk = ~pll_afi_clk;

	task automatic stop_run();
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic logic [1:0] past_req(input int idx);
		if (idx < 0)
			return 2'b00;
		return req_hist[idx];
	endfunction

	// Group-major DDIO beats to timeslot-major AFI beats
	function automatic afi_data_t to_afi_order(input afi_data_t d);
		afi_data_t o;
		int g;
		int s;
		o = '0;
		for (g = 0; g < NUM_DQS_GROUPS; g++)
			for (s = 0; s < TIMESLOTS; s++)
				o[s*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
					d[g*GROUP_DATA_WIDTH + s*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
		return o;
	endfunction

	// ****************************************
	// Reference models, updated on each edge
	// ****************************************
	always @(posedge pll_afi_clk)
	begin : model_update
		logic [1:0] r;
		int lat;
		int g;
		int k;
		cyc = cyc + 1;
		if (cyc >= TIMEOUT)
			report_error($sformatf("run did not finish within %0d cycles", TIMEOUT));
		req_hist[cyc] = reset_n_afi_clk ? {afi_rdata_en_full_i, afi_rdata_en_i} : 2'b00;
		if (reset_n_afi_clk)
		begin
			for (g = 0; g < NUM_DQS_GROUPS; g++)
				if (seq_read_increment_vfifo_i[g])
					vf_ptr[g] = (vf_ptr[g] + 1) % 8;
			// Writes start one edge after the sampled release
			if (wr_active && wr_count < WORDS)
			begin
				wr_words[wr_count] = ddio_phy_dq_i;
				wr_count++;
			end
			wr_active = !seq_read_fifo_reset_i[0];
			if (seq_read_fifo_reset_i[0])
			begin
				wr_count = 0;
				fifo_epoch++;
			end
			lat = int'(seq_read_latency_i);
			r = past_req(cyc - lat);
			exp_valid = r[0];
			// Termination stays on for requests one to six edges back
			exp_oct = 1'b1;
			for (k = 1; k <= 6; k++)
			begin
				r = past_req(cyc - k);
				if (r[1])
					exp_oct = 1'b0;
			end
			for (g = 0; g < NUM_DQS_GROUPS; g++)
			begin
				r = past_req(cyc - (vf_ptr[g] + 1));
				exp_dqs[g] = r[1];
			end
		end
		else
		begin
			exp_valid = 1'b0;
			exp_oct = 1'b0;
			exp_dqs = '0;
		end
	end

	// ****************************************
	// Checks at the falling edge
	// ****************************************
	valid_latency_chk: assert property (@(negedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid_o == exp_valid)
		else report_mismatch("afi_rdata_valid_o", 32'(afi_rdata_valid_o), 32'(exp_valid));

	dqs_enable_chk: assert property (@(negedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		dqs_enable_ctrl_o == exp_dqs)
		else report_mismatch("dqs_enable_ctrl_o", 32'(dqs_enable_ctrl_o), 32'(exp_dqs));

	oct_window_chk: assert property (@(negedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		force_oct_off_o == exp_oct)
		else report_mismatch("force_oct_off_o", 32'(force_oct_off_o), 32'(exp_oct));

	always @(negedge pll_afi_clk)
	begin : data_check
		afi_data_t expected;
		if (seen_epoch != fifo_epoch)
		begin
			seen_epoch = fifo_epoch;
			rd_k = 0;
		end
		if (!reset_n_afi_clk)
		begin
			assert (!afi_rdata_valid_o && dqs_enable_ctrl_o == '0 && !force_oct_off_o
				&& afi_rdata_o == '0)
				else report_error("outputs are not cleared during reset");
		end
		else if (data_check_on && afi_rdata_valid_o)
		begin
			if (rd_k >= wr_count)
				report_error("valid read data came before its word was written");
			expected = to_afi_order(wr_words[rd_k]);
			assert (afi_rdata_o == expected)
				else report_mismatch("afi_rdata_o", 32'(afi_rdata_o), 32'(expected));
			rd_k++;
			words_checked++;
		end
	end

	// ****************************************
	// Stimulus
	// ****************************************

	// New DDIO data is presented after every edge
	task automatic tick();
		@(posedge pll_afi_clk);
		#1;
		ddio_phy_dq_i = afi_data_t'(rand_bits(16));
	endtask

	task automatic idle(input int n);
		afi_rdata_en_i = 1'b0;
		afi_rdata_en_full_i = 1'b0;
		repeat (n) tick();
	endtask

	task automatic request(input logic on);
		afi_rdata_en_i = on;
		afi_rdata_en_full_i = on;
		tick();
	endtask

	// The latency settles over the quiet cycles before any request
	task automatic latency_phase(input int lat);
		logic [31:0] r;
		seq_read_latency_i = latency_t'(lat);
		idle(LAT_QUIET);
		repeat (LAT_RUN)
		begin
			// Narrow and full requests are drawn apart so each delay line shows
			r = rand_bits(2);
			afi_rdata_en_i = r[0];
			afi_rdata_en_full_i = r[1];
			tick();
		end
	endtask

	// One continuous burst keeps every read within the FIFO window
	task automatic data_phase(input int lat);
		seq_read_latency_i = latency_t'(lat);
		idle(LAT_QUIET);
		data_check_on = 1'b1;
		seq_read_fifo_reset_i = '1;
		repeat (3) tick();
		seq_read_fifo_reset_i = '0;
		repeat (2) tick();
		repeat (BURST_LEN) request(1'b1);
		idle(1);
		while (rd_k < BURST_LEN)
			tick();
		data_check_on = 1'b0;
	endtask

	task automatic vfifo_round(input int n0, input int n1);
		logic [31:0] r;
		int i;
		idle(10);
		for (i = 0; i < n0 || i < n1; i++)
		begin
			seq_read_increment_vfifo_i = {i < n1, i < n0};
			tick();
		end
		seq_read_increment_vfifo_i = '0;
		repeat (40)
		begin
			r = rand_bits(1);
			request(r[0]);
		end
	endtask

	initial
	begin
		reset_n_afi_clk = 1'b0;
		seq_read_fifo_reset_i = '0;
		seq_read_increment_vfifo_i = '0;
		seq_read_latency_i = latency_t'(2);
		afi_rdata_en_i = 1'b0;
		afi_rdata_en_full_i = 1'b0;
		ddio_phy_dq_i = '0;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		#1;
		reset_n_afi_clk = 1'b1;
		repeat (4)
		begin
			@(negedge pll_afi_clk);
			assert (afi_rdata_o == '0)
				else report_mismatch("afi_rdata_o", 32'(afi_rdata_o), 32'h0);
		end
		tick();
		latency_phase(2);
		data_phase(5);
		latency_phase(5);
		latency_phase(11);
		// Second reset restarts the word count mid-run
		data_phase(11);
		latency_phase(16);
		// Pointers go 3, 9, 13 and 5, 7, 16, so both wrap past 7
		vfifo_round(3, 5);
		vfifo_round(6, 2);
		vfifo_round(4, 9);
		// Isolated, back-to-back and gapped termination requests
		idle(10);
		request(1'b1);
		idle(9);
		repeat (3) request(1'b1);
		idle(8);
		request(1'b1);
		request(1'b0);
		request(1'b1);
		idle(TAIL);
		if (words_checked != 2 * BURST_LEN)
			report_error("fewer read words were checked than were requested");
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

// ==== rtl/read_datapath.sv ====
// Read datapath top level for a full-rate DDR2 PHY
// Per-group valid prediction and read FIFOs, latency tracking, AFI data reordering
module read_datapath (
	input  logic                  pll_afi_clk,
	input  logic                  reset_n_afi_clk,
	input  rdp_pkg::dqs_vec_t     seq_read_fifo_reset_i,
	input  rdp_pkg::dqs_vec_t     seq_read_increment_vfifo_i,
	input  rdp_pkg::latency_t     seq_read_latency_i,
	input  logic                  afi_rdata_en_i,
	input  logic                  afi_rdata_en_full_i,
	input  rdp_pkg::afi_data_t    ddio_phy_dq_i,
	output rdp_pkg::afi_data_t    afi_rdata_o,
	output logic                  afi_rdata_valid_o,
	output rdp_pkg::dqs_vec_t     dqs_enable_ctrl_o,
	output logic                  force_oct_off_o
);
	import rdp_pkg::*;

	// Latency-selected strobes, shared by every group
	logic rd_enable;
	logic rd_valid;

	// Registered valid from each read FIFO group
	dqs_vec_t grp_valid;

	// Group-major slices of the DDIO word and of the FIFO outputs
	group_data_t grp_wdata [NUM_DQS_GROUPS];
	group_data_t grp_rdata [NUM_DQS_GROUPS];

	// ****************************************
	// Sequencer and controller strobes
	// ****************************************

	// The bundle is driven here only and fans out to the blocks below
	read_calib_if cal ();

	assign cal.fifo_reset    = seq_read_fifo_reset_i;
	assign cal.vfifo_inc     = seq_read_increment_vfifo_i;
	assign cal.read_latency  = seq_read_latency_i;
	assign cal.rdata_en      = afi_rdata_en_i;
	assign cal.rdata_en_full = afi_rdata_en_full_i;

	// Shared latency delay, read enable and termination window
	read_latency_tracker read_latency_tracker_inst (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.cal             (cal.lat_mp),
		.rd_valid_o      (rd_valid),
		.rd_enable_o     (rd_enable),
		.force_oct_off_o (force_oct_off_o)
	);

	// ****************************************
	// Per DQS group blocks
	// ****************************************
	for (genvar g = 0; g < NUM_DQS_GROUPS; g++)
	begin : group_gen
		// DDIO word is group-major so each group owns one contiguous slice
		assign grp_wdata[g] = ddio_phy_dq_i[g*GROUP_DATA_WIDTH +: GROUP_DATA_WIDTH];

		// Token register that tells the I/O when to open the DQS gate
		vfifo_group #(
			.GROUP (g)
		) vfifo_group_inst (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.cal             (cal.vf_mp),
			.dqs_enable_o    (dqs_enable_ctrl_o[g])
		);

		// Data buffer between capture and the calibrated read point
		read_fifo_group #(
			.GROUP (g)
		) read_fifo_group_inst (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.cal             (cal.rf_mp),
			.wr_data_i       (grp_wdata[g]),
			.rd_enable_i     (rd_enable),
			.rd_valid_i      (rd_valid),
			.rd_data_o       (grp_rdata[g]),
			.rd_valid_o      (grp_valid[g])
		);

		// AFI word is timeslot-major, so each beat of this group lands
		// next to the same beat of the other groups
		for (genvar s = 0; s < TIMESLOTS; s++)
		begin : slot_gen
			assign afi_rdata_o[s*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				grp_rdata[g][s*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
		end
	end

	// Word is valid only when every group presents valid data
	assign afi_rdata_valid_o = &grp_valid;

endmodule

// ==== rtl/read_latency_tracker.sv ====
// Read latency delay lines with tap selection for valid and read enable
// On-die termination force-off window built from the full read request
module read_latency_tracker (
	input  logic         pll_afi_clk,
	input  logic         reset_n_afi_clk,
	read_calib_if.lat_mp cal,
	output logic         rd_valid_o,
	output logic         rd_enable_o,
	output logic         force_oct_off_o
);
	import rdp_pkg::*;

	// Bit i holds the request sampled i edges before the most recent one
	logic [MAX_READ_LATENCY-1:0] latency_shifter;
	logic [MAX_READ_LATENCY-1:0] full_latency_shifter;

	// Recent history of the full request for the termination window
	logic [OCT_OFF_DELAY-1:0] oct_shifter;

	// Tap index into the delay lines
	latency_t lat_minus_one;
	logic [LATENCY_WIDTH-2:0] tap_sel;

	// ****************************************
	// Latency delay lines
	// ****************************************
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter      <= '0;
			full_latency_shifter <= '0;
		end
		else
		begin
			latency_shifter      <= {latency_shifter[MAX_READ_LATENCY-2:0], cal.rdata_en};
			full_latency_shifter <= {full_latency_shifter[MAX_READ_LATENCY-2:0],
				cal.rdata_en_full};
		end
	end

	// The read FIFO adds one register stage, so the tap is one short of
	// the programmed latency
	assign lat_minus_one = cal.read_latency - latency_t'(1);
	// Legal latencies 2 to 16 map to taps 1 to 15, so the top bit is always clear
	assign tap_sel = lat_minus_one[LATENCY_WIDTH-2:0];

	// Valid follows the narrow request, read enable the full request
	assign rd_valid_o  = latency_shifter[tap_sel];
	assign rd_enable_o = full_latency_shifter[tap_sel];

	// ****************************************
	// Termination force-off window
	// ****************************************

	// Termination stays on while any request sits between the on and off delays
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			oct_shifter     <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			oct_shifter <= {oct_shifter[OCT_OFF_DELAY-2:0], cal.rdata_en_full};
			// Bit 0 is the request one edge back, so the window spans bits
			// OCT_ON_DELAY-1 up to OCT_OFF_DELAY-1
			force_oct_off_o <= ~(|oct_shifter[OCT_OFF_DELAY-1:OCT_ON_DELAY-1]);
		end
	end

endmodule

// ==== read_fifo/read_fifo_group.sv ====
// Read FIFO for one DQS group built from flops
// Free-running write side with registered reset, enable-driven read side
module read_fifo_group #(
	parameter int GROUP = 0
) (
	input  logic                 pll_afi_clk,
	input  logic                 reset_n_afi_clk,
	read_calib_if.rf_mp          cal,
	input  rdp_pkg::group_data_t wr_data_i,
	input  logic                 rd_enable_i,
	input  logic                 rd_valid_i,
	output rdp_pkg::group_data_t rd_data_o,
	output logic                 rd_valid_o
);
	import rdp_pkg::*;

	// Write side runs only once the registered FIFO reset has released
	logic wr_rst_n;

	rf_addr_t wr_ptr;
	rf_addr_t rd_ptr;

	// One entry per AFI cycle of captured data
	group_data_t fifo_mem [READ_FIFO_DEPTH];

	// ****************************************
	// Write side
	// ****************************************

	// The sequencer reset is registered once before it reaches the write
	// pointer, so the first write lands on the second edge after release
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_rst_n <= 1'b0;
		end
		else
		begin
			wr_rst_n <= ~cal.fifo_reset[GROUP];
		end
	end

	// Capture data arrives every cycle, so the pointer advances every cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
		end
		else if (!wr_rst_n)
		begin
			wr_ptr <= '0;
		end
		else
		begin
			wr_ptr <= wr_ptr + rf_addr_t'(1);
		end
	end

	// Storage is written with the same gating as the pointer
	always_ff @(posedge pll_afi_clk)
	begin
		if (wr_rst_n)
		begin
			fifo_mem[wr_ptr] <= wr_data_i;
		end
	end

	// ****************************************
	// Read side
	// ****************************************

	// Read pointer clears directly on the sequencer reset, one edge ahead
	// of the write pointer, so both restart from entry 0
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rd_ptr     <= '0;
			rd_data_o  <= '0;
			rd_valid_o <= 1'b0;
		end
		else
		begin
			if (cal.fifo_reset[GROUP])
				rd_ptr <= '0;
			else if (rd_enable_i)
				rd_ptr <= rd_ptr + rf_addr_t'(1);

			// Data and valid are registered on the same edge to stay aligned
			if (rd_enable_i)
				rd_data_o <= fifo_mem[rd_ptr];
			rd_valid_o <= rd_valid_i;
		end
	end

endmodule

// ==== valid_predict/vfifo_group.sv ====
// Valid prediction for one DQS group
// Write pointer under sequencer control and the token shift register
module vfifo_group #(
	parameter int GROUP = 0
) (
	input  logic        pll_afi_clk,
	input  logic        reset_n_afi_clk,
	read_calib_if.vf_mp cal,
	output logic        dqs_enable_o
);
	import rdp_pkg::*;

	// Insertion offset of the next token, in AFI cycles
	vf_addr_t wr_ptr;

	// Absolute bit position that receives the token
	logic [VFIFO_ADDR_WIDTH:0] wr_pos;

	// Tokens travel toward bit 0, one position per cycle
	logic [VFIFO_LENGTH-1:0] token_shifter;

	// ****************************************
	// Write pointer
	// ****************************************

	// Each increment pulse delays the predicted valid by one more cycle.
	// The pointer wraps modulo its width like a FIFO address
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			wr_ptr <= '0;
		end
		else if (cal.vfifo_inc[GROUP])
		begin
			wr_ptr <= wr_ptr + vf_addr_t'(1);
		end
	end

	// Extra stages keep bit 0 clear of the insertion point
	assign wr_pos = {1'b0, wr_ptr} + (VFIFO_ADDR_WIDTH + 1)'(VFIFO_EXTRA_STAGES);

	// ****************************************
	// Token shift register
	// ****************************************

	// A token written at position P+1 reaches bit 0 after P+1 edges
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			token_shifter <= '0;
		end
		else
		begin
			token_shifter <= {1'b0, token_shifter[VFIFO_LENGTH-1:1]};
			// The new request overrides whatever shifts into the insertion bit
			token_shifter[wr_pos] <= cal.rdata_en_full;
		end
	end

	// Bit 0 drives the DQS enable of this group
	assign dqs_enable_o = token_shifter[0];

endmodule

// ==== common/read_calib_if.sv ====
// Sequencer calibration controls and controller read requests
// One modport for each block that consumes them
interface read_calib_if;
	import rdp_pkg::*;

	// Per-group FIFO reset from the sequencer, held high while the FIFO is flushed
	dqs_vec_t fifo_reset;

	// Per-group strobe that moves the valid prediction point out by one cycle
	dqs_vec_t vfifo_inc;

	// Calibrated read latency, stable while reads are in flight
	latency_t read_latency;

	// Read requests from the controller
	logic rdata_en;
	logic rdata_en_full;

	// Latency tracker needs the latency and both request strobes
	modport lat_mp (
		input read_latency,
		input rdata_en,
		input rdata_en_full
	);

	// Valid prediction only looks at its increment bit and the full request
	modport vf_mp (
		input vfifo_inc,
		input rdata_en_full
	);

	// Read FIFO only needs its reset
	modport rf_mp (
		input fifo_reset
	);

endinterface

// ==== common/rdp_pkg.sv ====
// Shared widths, depths and delays of the read datapath
// Vector types for AFI data, group data, latency and FIFO addresses
package rdp_pkg;

	// Interface geometry for a full-rate core with two read DQS groups
	localparam int NUM_DQS_GROUPS   = 2;
	localparam int DQ_GROUP_WIDTH   = 4;
	localparam int MEM_DQ_WIDTH     = NUM_DQS_GROUPS * DQ_GROUP_WIDTH;
	localparam int TIMESLOTS        = 2;
	localparam int AFI_DATA_WIDTH   = MEM_DQ_WIDTH * TIMESLOTS;
	localparam int GROUP_DATA_WIDTH = DQ_GROUP_WIDTH * TIMESLOTS;

	// Read FIFO holds one AFI word per entry
	localparam int READ_FIFO_DEPTH      = 16;
	localparam int READ_FIFO_ADDR_WIDTH = 4;

	// Valid prediction token register is one pointer span plus the extra flop stages
	localparam int VFIFO_ADDR_WIDTH   = 3;
	localparam int VFIFO_EXTRA_STAGES = 1;
	localparam int VFIFO_LENGTH       = (2 ** VFIFO_ADDR_WIDTH) + VFIFO_EXTRA_STAGES;

	// Read latency range that the sequencer may program
	localparam int MAX_READ_LATENCY = 16;
	localparam int LATENCY_WIDTH    = 5;

	// Termination window, derived from the memory read latency
	localparam int MEM_T_RL      = 6;
	localparam int OCT_ON_DELAY  = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// AFI read data and the DDIO capture word share one width
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;

	// Both beats of one DQS group in a single AFI cycle
	typedef logic [GROUP_DATA_WIDTH-1:0] group_data_t;

	// One bit per read DQS group
	typedef logic [NUM_DQS_GROUPS-1:0] dqs_vec_t;

	// Read latency in AFI cycles
	typedef logic [LATENCY_WIDTH-1:0] latency_t;

	// Read FIFO and valid prediction pointers
	typedef logic [READ_FIFO_ADDR_WIDTH-1:0] rf_addr_t;
	typedef logic [VFIFO_ADDR_WIDTH-1:0] vf_addr_t;

endpackage
